// File: logic/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Data path width, fixed by RV32I.
`define XLEN 32

// Architectural register file.
`define REG_COUNT 32
`define REG_ADDR_W 5

`endif

// File: logic/isa_pkg.sv
package isa_pkg;

    // Major opcodes handled by the core.
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,
        SLTU   = 4'd4,
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        OR     = 4'd8,
        AND    = 4'd9,
        PASS_B = 4'd10  // LUI.
    } alu_op_e;

    // funct3 field of OP and OP_IMM.
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;  // SRL and SRA.
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 values, ALT selects SUB and SRA.
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

// File: logic/pipe_pkg.sv
`include "core_params.svh"

package pipe_pkg;

    // Decode to execute.
    typedef struct packed {
        isa_pkg::alu_op_e        alu_op;
        logic [`XLEN-1:0]        op_a;
        logic [`XLEN-1:0]        op_b;
        logic [`REG_ADDR_W-1:0]  rd;
        logic                    writes_rd;
        logic                    illegal;
    } dec_info_t;

    // Result of an older instruction, offered to decode.
    typedef struct packed {
        logic                    valid;
        logic [`REG_ADDR_W-1:0]  rd;
        logic [`XLEN-1:0]        value;
    } fwd_t;

    // One record per retired instruction.
    typedef struct packed {
        logic [`REG_ADDR_W-1:0]  rd;
        logic [`XLEN-1:0]        value;
        logic                    illegal;
    } retire_t;

endpackage

// File: logic/reg_file.sv
`include "core_params.svh"

module reg_file (
    input  logic                   clock,
    input  logic                   arst_n,
    input  logic [`REG_ADDR_W-1:0] rs1_addr,
    input  logic [`REG_ADDR_W-1:0] rs2_addr,
    output logic [`XLEN-1:0]       rs1_data,
    output logic [`XLEN-1:0]       rs2_data,
    input  logic                   wr_en,
    input  logic [`REG_ADDR_W-1:0] wr_addr,
    input  logic [`XLEN-1:0]       wr_data
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin  // x0 is never written.
            regs[wr_addr] <= wr_data;
        end
    end

    // Same-cycle write is visible on the read ports.
    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
        logic [`XLEN-1:0] data;
        if (addr == '0) begin
            data = '0;
        end else if (wr_en && wr_addr == addr) begin
            data = wr_data;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

    // A write to x0 never shows up on a read of x0.
    x0_write_dropped: assert property (
        @(posedge clock) disable iff (!arst_n)
        wr_en && wr_addr == '0 |-> (rs1_addr != '0 || rs1_data == '0) &&
                                   (rs2_addr != '0 || rs2_data == '0)
    );

endmodule

// File: logic/inst_decode.sv
`include "core_params.svh"

module inst_decode (
    input  logic                   clock,
    input  logic                   arst_n,
    input  logic                   stall,
    input  logic                   inst_valid,
    output logic                   inst_ready,
    input  logic [`XLEN-1:0]       inst,
    output logic [`REG_ADDR_W-1:0] rs1_addr,
    output logic [`REG_ADDR_W-1:0] rs2_addr,
    input  logic [`XLEN-1:0]       rs1_data,
    input  logic [`XLEN-1:0]       rs2_data,
    input  pipe_pkg::fwd_t         exe_fwd,
    output logic                   dec_valid,
    output pipe_pkg::dec_info_t    dec
);
    import isa_pkg::*;

    logic                   accept;
    logic                   valid_q;
    logic [`XLEN-1:0]       inst_q;
    opcode_e                opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic [`XLEN-1:0]       imm;
    alu_op_e                alu_op;
    logic                   legal;
    logic                   use_imm;
    logic                   fwd_rs1;
    logic                   fwd_rs2;

    function automatic alu_op_e funct3_to_op(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            F3_ADD_SUB: op = alt ? SUB : ADD;
            F3_SLL:     op = SLL;
            F3_SLT:     op = SLT;
            F3_SLTU:    op = SLTU;
            F3_XOR:     op = XOR;
            F3_SR:      op = alt ? SRA : SRL;
            F3_OR:      op = OR;
            F3_AND:     op = AND;
            default:    op = ADD;
        endcase
        return op;
    endfunction

    assign inst_ready = !stall;
    assign accept     = inst_valid && inst_ready;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= accept;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            inst_q <= inst;
        end
    end

    assign opcode   = opcode_e'(inst_q[6:0]);
    assign funct3   = inst_q[14:12];
    assign funct7   = inst_q[31:25];
    assign rs1_addr = inst_q[19:15];
    assign rs2_addr = inst_q[24:20];

    // U immediate for LUI, sign-extended I immediate otherwise.
    assign imm = (opcode == LUI) ? {inst_q[31:12], 12'b0}
                                 : {{(`XLEN-12){inst_q[31]}}, inst_q[31:20]};

    always_comb begin
        alu_op  = ADD;
        legal   = 1'b0;
        use_imm = 1'b0;
        case (opcode)
            OP: begin
                alu_op = funct3_to_op(funct3, funct7[5]);
                legal  = (funct7 == F7_BASE) ||
                         (funct7 == F7_ALT && (funct3 == F3_ADD_SUB || funct3 == F3_SR));
            end
            OP_IMM: begin
                use_imm = 1'b1;
                alu_op  = funct3_to_op(funct3, funct3 == F3_SR && funct7[5]);
                if (funct3 == F3_SLL) begin
                    legal = (funct7 == F7_BASE);
                end else if (funct3 == F3_SR) begin
                    legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                end else begin
                    legal = 1'b1;
                end
            end
            LUI: begin
                alu_op  = PASS_B;
                use_imm = 1'b1;
                legal   = 1'b1;
            end
            default: ;  // Stays illegal.
        endcase
    end

    // Execute holds the newest value, the register file covers the rest.
    assign fwd_rs1 = exe_fwd.valid && exe_fwd.rd == rs1_addr && rs1_addr != '0;
    assign fwd_rs2 = exe_fwd.valid && exe_fwd.rd == rs2_addr && rs2_addr != '0;

    always_comb begin
        dec.alu_op    = alu_op;
        dec.op_a      = fwd_rs1 ? exe_fwd.value : rs1_data;
        dec.op_b      = use_imm ? imm : (fwd_rs2 ? exe_fwd.value : rs2_data);
        dec.rd        = inst_q[11:7];
        dec.writes_rd = legal;
        dec.illegal   = !legal;
    end

    assign dec_valid = valid_q;

    // Nothing enters and the forwarding source holds while the retire stream is held.
    hold_on_stall: assert property (
        @(posedge clock) disable iff (!arst_n)
        stall |-> !inst_ready ##1 $stable(exe_fwd)
    );

endmodule

// File: logic/execute.sv
`include "core_params.svh"

module execute (
    input  logic                clock,
    input  logic                arst_n,
    input  logic                stall,
    input  logic                dec_valid,
    input  pipe_pkg::dec_info_t dec,
    output pipe_pkg::fwd_t      exe_fwd,
    output logic                exe_valid,
    output pipe_pkg::retire_t   exe_result
);
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int SHAMT_W = $clog2(`XLEN);

    logic               valid_q;
    dec_info_t          dec_q;
    logic [`XLEN-1:0]   a;
    logic [`XLEN-1:0]   b;
    logic [SHAMT_W-1:0] shamt;
    logic [`XLEN-1:0]   result;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= dec_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            dec_q <= dec;
        end
    end

    assign a     = dec_q.op_a;
    assign b     = dec_q.op_b;
    assign shamt = b[SHAMT_W-1:0];  // Upper bits of b ignored.

    always_comb begin
        case (dec_q.alu_op)
            ADD:     result = a + b;
            SUB:     result = a - b;
            SLL:     result = a << shamt;
            SLT:     result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            SLTU:    result = {{(`XLEN-1){1'b0}}, a < b};
            XOR:     result = a ^ b;
            SRL:     result = a >> shamt;
            SRA:     result = $unsigned($signed(a) >>> shamt);
            OR:      result = a | b;
            AND:     result = a & b;
            PASS_B:  result = b;
            default: result = '0;
        endcase
    end

    always_comb begin
        exe_fwd.valid = valid_q && !dec_q.illegal && dec_q.writes_rd;
        exe_fwd.rd    = dec_q.rd;
        exe_fwd.value = result;
    end

    always_comb begin
        exe_result.rd      = dec_q.rd;
        exe_result.value   = dec_q.illegal ? '0 : result;  // Illegal records carry zero.
        exe_result.illegal = dec_q.illegal;
    end

    assign exe_valid = valid_q;

    // Decode hands over a known, listed operation even for illegal words.
    alu_op_known: assert property (
        @(posedge clock) disable iff (!arst_n)
        valid_q |-> !$isunknown(dec_q.alu_op) && dec_q.alu_op <= PASS_B
    );

endmodule

// File: logic/write_back.sv
`include "core_params.svh"

module write_back (
    input  logic                   clock,
    input  logic                   arst_n,
    input  logic                   stall,
    input  logic                   exe_valid,
    input  pipe_pkg::retire_t      exe_result,
    output logic                   retire_valid,
    input  logic                   retire_ready,
    output pipe_pkg::retire_t      retire,
    output logic                   wr_en,
    output logic [`REG_ADDR_W-1:0] wr_addr,
    output logic [`XLEN-1:0]       wr_data
);
    import pipe_pkg::*;

    logic    valid_q;
    retire_t rec_q;
    logic    transfer;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= exe_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            rec_q <= exe_result;
        end
    end

    assign retire_valid = valid_q;
    assign retire       = rec_q;
    assign transfer     = retire_valid && retire_ready;

    // Register write only on the retire handshake.
    assign wr_en   = transfer && !rec_q.illegal;
    assign wr_addr = rec_q.rd;
    assign wr_data = rec_q.value;

    retire_stable: assert property (
        @(posedge clock) disable iff (!arst_n)
        retire_valid && !retire_ready |=> retire_valid && $stable(retire)
    );

endmodule

// File: logic/core.sv
`include "core_params.svh"

module core (
    input  logic              clock,
    input  logic              arst_n,
    input  logic              inst_valid,
    output logic              inst_ready,
    input  logic [`XLEN-1:0]  inst,
    output logic              retire_valid,
    input  logic              retire_ready,
    output pipe_pkg::retire_t retire
);
    import pipe_pkg::*;

    logic                   stall;
    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    logic                   wr_en;
    logic [`REG_ADDR_W-1:0] wr_addr;
    logic [`XLEN-1:0]       wr_data;
    fwd_t                   exe_fwd;
    logic                   dec_valid;
    dec_info_t              dec;
    logic                   exe_valid;
    retire_t                exe_result;

    assign stall = retire_valid && !retire_ready;  // Freezes every stage.

    inst_decode u_decode (
        .clock      (clock),
        .arst_n     (arst_n),
        .stall      (stall),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst       (inst),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .exe_fwd    (exe_fwd),
        .dec_valid  (dec_valid),
        .dec        (dec)
    );

    execute u_execute (
        .clock      (clock),
        .arst_n     (arst_n),
        .stall      (stall),
        .dec_valid  (dec_valid),
        .dec        (dec),
        .exe_fwd    (exe_fwd),
        .exe_valid  (exe_valid),
        .exe_result (exe_result)
    );

    write_back u_write_back (
        .clock        (clock),
        .arst_n       (arst_n),
        .stall        (stall),
        .exe_valid    (exe_valid),
        .exe_result   (exe_result),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire       (retire),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data)
    );

    reg_file u_reg_file (
        .clock    (clock),
        .arst_n   (arst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

endmodule

// File: tests/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [31:0]      rng_state = 32'd66;
logic [`XLEN-1:0] model_regs [`REG_COUNT];

function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

// Mostly x0..x7, so that dependencies land close together.
function automatic logic [4:0] pick_reg(input logic [31:0] r);
    return r[7] ? r[4:0] : {2'b00, r[2:0]};
endfunction

function automatic logic [31:0] random_inst();
    logic [31:0] r;
    logic [31:0] s;
    int unsigned pct;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] word;
    r   = xorshift32();
    s   = xorshift32();
    pct = s % 100;
    f3  = r[10:8];
    rd  = pick_reg(r);
    rs1 = pick_reg(r >> 11);
    rs2 = pick_reg(r >> 19);
    if (pct < 3) begin
        word = {s[31:7] ^ r[31:7], r[30] ? 7'b0000011 : 7'b1100011};  // Load or branch.
    end else if (pct < 5) begin
        word = {7'b0000001, rs2, rs1, f3, rd, OP};  // M extension, not supported.
    end else if (pct < 45) begin
        f7   = ((f3 == F3_ADD_SUB || f3 == F3_SR) && r[29]) ? F7_ALT : F7_BASE;
        word = {f7, rs2, rs1, f3, rd, OP};
    end else if (pct < 85) begin
        imm = s[31:20];
        if (f3 == F3_SLL) begin
            imm[11:5] = F7_BASE;
        end else if (f3 == F3_SR) begin
            imm[11:5] = r[29] ? F7_ALT : F7_BASE;
        end
        word = {imm, rs1, f3, rd, OP_IMM};
    end else begin
        word = {s[31:12], rd, LUI};
    end
    return word;
endfunction

function automatic logic [`XLEN-1:0] alu_model(input logic [2:0] f3, input logic alt,
                                               input logic [`XLEN-1:0] a,
                                               input logic [`XLEN-1:0] b);
    logic [4:0]       sh;
    logic [`XLEN-1:0] res;
    sh = b[4:0];
    case (f3)
        F3_ADD_SUB: res = alt ? a - b : a + b;
        F3_SLL:     res = a << sh;
        F3_SLT:     res = (a[31] != b[31]) ? a[31] : (a < b);  // Sign decides first.
        F3_SLTU:    res = a < b;
        F3_XOR:     res = a ^ b;
        F3_SR:      res = alt ? ((a >> sh) | ({`XLEN{a[31]}} & ~({`XLEN{1'b1}} >> sh)))
                              : a >> sh;
        F3_OR:      res = a | b;
        default:    res = a & b;
    endcase
    return res;
endfunction

// Expected record for one accepted word, in acceptance order.
function automatic retire_t model_retire(input logic [31:0] w);
    retire_t          rec;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] res;
    logic [2:0]       f3;
    logic [6:0]       f7;
    logic             alt;
    logic             legal;
    a     = model_regs[w[19:15]];
    b     = model_regs[w[24:20]];
    f3    = w[14:12];
    f7    = w[31:25];
    alt   = 1'b0;
    legal = 1'b1;
    case (w[6:0])
        OP: begin
            alt   = (f7 == F7_ALT);
            legal = (f7 == F7_BASE) || (alt && (f3 == F3_ADD_SUB || f3 == F3_SR));
        end
        OP_IMM: begin
            b   = {{(`XLEN-12){w[31]}}, w[31:20]};
            alt = (f3 == F3_SR) && (f7 == F7_ALT);
            if (f3 == F3_SLL) begin
                legal = (f7 == F7_BASE);
            end else if (f3 == F3_SR) begin
                legal = (f7 == F7_BASE) || alt;
            end
        end
        LUI:     b = {w[31:12], 12'b0};
        default: legal = 1'b0;
    endcase
    res         = (w[6:0] == LUI) ? b : alu_model(f3, alt, a, b);
    rec.rd      = w[11:7];
    rec.value   = legal ? res : '0;
    rec.illegal = !legal;
    if (legal && w[11:7] != 5'd0) begin
        model_regs[w[11:7]] = res;
    end
    return rec;
endfunction

`endif

// File: tests/tb_core.sv
`include "core_params.svh"

module tb_core;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int NUM_INST     = 2000;
    localparam int PERIOD       = 100;
    localparam int RESET_CYCLES = 10;
    localparam longint TIMEOUT  = (longint'(NUM_INST) * 8 + RESET_CYCLES) * PERIOD;

    logic             clock;
    logic             arst_n;
    logic             inst_valid;
    logic             inst_ready;
    logic [`XLEN-1:0] inst;
    logic             retire_valid;
    logic             retire_ready;
    retire_t          retire;

    int      errors = 0;
    int      sent = 0;
    int      retired = 0;
    logic    driving = 1'b0;
    logic    will_accept = 1'b0;
    logic    held_valid = 1'b0;
    retire_t held_rec;
    retire_t expect_q [$];

    `include "tb_model.svh"

    core DUT (
        .clock        (clock),
        .arst_n       (arst_n),
        .inst_valid   (inst_valid),
        .inst_ready   (inst_ready),
        .inst         (inst),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire       (retire)
    );

    always #(PERIOD / 2) clock = ~clock;

    task automatic check_retire();
        retire_t exp;
        assert (expect_q.size() > 0) else begin
            errors++;
            $display("Error at %0t: a record retired with no instruction outstanding", $time);
        end
        if (expect_q.size() > 0) begin
            exp = expect_q.pop_front();
            assert (retire.rd == exp.rd) else begin
                errors++;
                $display("Error at %0t: retire.rd expected %0d, got %0d",
                         $time, exp.rd, retire.rd);
            end
            assert (retire.value == exp.value) else begin
                errors++;
                $display("Error at %0t: retire.value expected %08h, got %08h",
                         $time, exp.value, retire.value);
            end
            assert (retire.illegal == exp.illegal) else begin
                errors++;
                $display("Error at %0t: retire.illegal expected %b, got %b",
                         $time, exp.illegal, retire.illegal);
            end
        end
        retired++;
    endtask

    // Mid-cycle sampling, handshakes complete at the next rising edge.
    always @(negedge clock) begin
        if (arst_n) begin
            if (held_valid) begin
                assert (retire_valid) else begin
                    errors++;
                    $display("Error at %0t: retire_valid expected 1 while stalled, got %b",
                             $time, retire_valid);
                end
                assert (retire === held_rec) else begin
                    errors++;
                    $display("Error at %0t: retire expected %h while stalled, got %h",
                             $time, held_rec, retire);
                end
            end
            held_valid = retire_valid && !retire_ready;
            held_rec   = retire;
            if (retire_valid && retire_ready) begin
                check_retire();
            end
            will_accept = inst_valid && inst_ready;
            if (will_accept) begin
                expect_q.push_back(model_retire(inst));
            end
        end
    end

    always begin
        @(posedge clock);
        #5;
        if (driving) begin
            if (!inst_valid || will_accept) begin  // Word held until accepted.
                if (sent < NUM_INST && xorshift32() % 5 != 0) begin
                    inst       = random_inst();
                    inst_valid = 1'b1;
                    sent++;
                end else begin
                    inst_valid = 1'b0;
                end
            end
            retire_ready = (xorshift32() % 4) != 0;
        end
    end

    initial begin
        #(TIMEOUT);
        errors++;
        $display("Error: the pipeline stopped retiring, %0d of %0d instructions retired",
                 retired, NUM_INST);
        $display("errors: %0d", errors);
        $display("test failed");
        $finish;
    end

    initial begin
        clock        = 1'b0;
        arst_n       = 1'b0;
        inst_valid   = 1'b0;
        inst         = '0;
        retire_ready = 1'b1;
        for (int i = 0; i < `REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clock);
        #5;
        arst_n = 1'b1;
        @(negedge clock);
        assert (retire_valid == 1'b0) else begin
            errors++;
            $display("Error at %0t: retire_valid expected 0 after reset, got %b",
                     $time, retire_valid);
        end
        assert (inst_ready == 1'b1) else begin
            errors++;
            $display("Error at %0t: inst_ready expected 1 after reset, got %b",
                     $time, inst_ready);
        end
        driving = 1'b1;
        wait (retired == NUM_INST);
        repeat (10) @(negedge clock);  // Catches any extra retire.
        assert (expect_q.size() == 0) else begin
            errors++;
            $display("Error: %0d accepted instructions never retired", expect_q.size());
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+logic
+incdir+tests
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/reg_file.sv
logic/inst_decode.sv
logic/execute.sv
logic/write_back.sv
logic/core.sv
tests/tb_core.sv
